// ==== common/dsp_router_defs.svh ====
// widths, counts, select codes and register offsets of the signal router
`ifndef DSP_ROUTER_DEFS_SVH
`define DSP_ROUTER_DEFS_SVH

// sample and accumulator widths
`define SAMPLE_W   14
`define SUM_W      15      // one guard bit for two direct inputs

// routing select code
`define SEL_W      3
`define SEL_NONE   7       // sink drives zero

// bus address split
`define SLOT_W     4
`define SLOT_LSB   16      // offset lives below this bit

// routing dimensions
`define N_SOURCES  6       // asg1 asg2 adc1 adc2 dac1 dac2
`define N_SINKS    4       // scope1 scope2 pwm0 pwm1
`define N_DIRECT   2       // asg direct paths into the mixer

// register offsets inside a slot
`define REG_INSEL  16'h0000
`define REG_OUTSEL 16'h0004
`define REG_SAT    16'h0008
`define REG_SIGNAL 16'h0010

`endif

// ==== common/dsp_router_pkg.sv ====
// sample, sum, select and output-select types with source and sink index enums
`default_nettype none

`include "dsp_router_defs.svh"

package dsp_router_pkg;

   // raw adc/dac/asg sample, two's complement
   typedef logic signed [`SAMPLE_W-1:0] sample_t;

   // mixer accumulator
   typedef logic signed [`SUM_W-1:0] sum_t;

   // which source feeds a sink
   typedef logic [`SEL_W-1:0] src_sel_t;

   // dac enable mask of a direct path
   typedef logic [1:0] out_sel_t;   // bit 0 dac1, bit 1 dac2

   // position of each source in the sources array
   typedef enum logic [`SEL_W-1:0] {
      SRC_ASG1 = 3'd0,
      SRC_ASG2 = 3'd1,
      SRC_ADC1 = 3'd2,
      SRC_ADC2 = 3'd3,
      SRC_DAC1 = 3'd4,   // fed back from mixer
      SRC_DAC2 = 3'd5
   } src_idx_e;

   // position of each sink in the sinks array
   typedef enum logic [1:0] {
      SINK_SCOPE1 = 2'd0,
      SINK_SCOPE2 = 2'd1,
      SINK_PWM0   = 2'd2,
      SINK_PWM1   = 2'd3
   } sink_idx_e;

endpackage

`default_nettype wire

// ==== source/signal_crossbar.sv ====
// per-sink source multiplexers with zero output for the no-source code
`timescale 1ns/1ps
`default_nettype none

`include "dsp_router_defs.svh"

module signal_crossbar (
   input  dsp_router_pkg::sample_t  sources_i [`N_SOURCES],
   input  dsp_router_pkg::src_sel_t in_sel_i  [`N_SINKS],
   output dsp_router_pkg::sample_t  sinks_o   [`N_SINKS]
);
   import dsp_router_pkg::*;

   genvar s;

   generate
      for (s = 0; s < `N_SINKS; s++) begin : g_sink
         src_sel_t sel;   // code for this sink
         logic     valid;

         assign sel = in_sel_i[s];

         // codes past the last source, none included, give silence
         assign valid = (sel != src_sel_t'(`SEL_NONE)) && (sel < `N_SOURCES);

         assign sinks_o[s] = valid ? sources_i[sel] : '0;
      end
   endgenerate

endmodule

`default_nettype wire

// ==== source/dsp_router_regs.sv ====
// bus-mapped routing and mixing registers, readback mux, ack and err generation
`timescale 1ns/1ps
`default_nettype none

`include "dsp_router_defs.svh"

module dsp_router_regs (
   input  logic                     clk_i,
   input  logic                     rstn_i,
   input  logic [31:0]              sys_addr_i,
   input  logic [31:0]              sys_wdata_i,
   input  logic                     sys_wen_i,
   input  logic                     sys_ren_i,
   input  dsp_router_pkg::sample_t  sources_i [`N_SOURCES],
   input  logic                     sat_a_i,
   input  logic                     sat_b_i,
   output dsp_router_pkg::src_sel_t in_sel_o  [`N_SINKS],
   output dsp_router_pkg::out_sel_t out_sel_o [`N_DIRECT],
   output logic [31:0]              sys_rdata_o,
   output logic                     sys_ack_o,
   output logic                     sys_err_o
);
   import dsp_router_pkg::*;

   localparam int SINK_IW = $clog2(`N_SINKS);
   localparam int DIR_IW  = $clog2(`N_DIRECT);
   localparam int SRC_IW  = $clog2(`N_SOURCES);

   logic [`SLOT_W-1:0]   slot;      // block number
   logic [`SLOT_LSB-1:0] offs;      // register inside the block
   logic [31:0]          rdata_d;
   src_sel_t             in_sel_q  [`N_SINKS];
   out_sel_t             out_sel_q [`N_DIRECT];

   assign slot = sys_addr_i[`SLOT_LSB +: `SLOT_W];
   assign offs = sys_addr_i[`SLOT_LSB-1:0];

   // routing registers
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         in_sel_q[SINK_SCOPE1] <= SRC_ADC1;   // scopes watch the adcs
         in_sel_q[SINK_SCOPE2] <= SRC_ADC2;
         in_sel_q[SINK_PWM0]   <= src_sel_t'(`SEL_NONE);   // pwm idle
         in_sel_q[SINK_PWM1]   <= src_sel_t'(`SEL_NONE);
         for (int k = 0; k < `N_DIRECT; k++) begin
            out_sel_q[k] <= '0;   // direct paths off
         end
      end else if (sys_wen_i) begin
         if (offs == `REG_INSEL && slot < `N_SINKS)
            in_sel_q[slot[SINK_IW-1:0]] <= sys_wdata_i[`SEL_W-1:0];
         if (offs == `REG_OUTSEL && slot < `N_DIRECT)
            out_sel_q[slot[DIR_IW-1:0]] <= sys_wdata_i[1:0];
         // anything else dropped silently
      end
   end

   // readback select, zero for unknown slot or offset
   always_comb begin
      rdata_d = '0;
      case (offs)
         `REG_INSEL: begin
            if (slot < `N_SINKS)
               rdata_d = 32'(in_sel_q[slot[SINK_IW-1:0]]);
         end
         `REG_OUTSEL: begin
            if (slot < `N_DIRECT)
               rdata_d = 32'(out_sel_q[slot[DIR_IW-1:0]]);
         end
         `REG_SAT: rdata_d = {30'd0, sat_b_i, sat_a_i};   // dac2 in bit 1
         `REG_SIGNAL: begin
            // raw sample bits, upper word stays zero
            if (slot < `N_SOURCES)
               rdata_d = {{(32-`SAMPLE_W){1'b0}}, sources_i[slot[SRC_IW-1:0]]};
         end
         default: rdata_d = '0;
      endcase
   end

   // one cycle strobe to ack, data alongside
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         sys_ack_o   <= 1'b0;
         sys_err_o   <= 1'b0;
         sys_rdata_o <= '0;
      end else begin
         sys_ack_o <= sys_wen_i | sys_ren_i;
         sys_err_o <= 1'b0;   // no error response on this bus
         if (sys_wen_i | sys_ren_i)
            sys_rdata_o <= rdata_d;   // hold last read otherwise
      end
   end

   assign in_sel_o  = in_sel_q;
   assign out_sel_o = out_sel_q;

endmodule

`default_nettype wire

// ==== dac_mixer/dac_mixer.sv ====
// masked two-stage summing pipeline with saturation onto the two dac channels
`timescale 1ns/1ps
`default_nettype none

`include "dsp_router_defs.svh"

module dac_mixer (
   input  logic                     clk_i,
   input  logic                     rstn_i,
   input  dsp_router_pkg::sample_t  direct_i  [`N_DIRECT],
   input  dsp_router_pkg::out_sel_t out_sel_i [`N_DIRECT],
   output dsp_router_pkg::sample_t  dat_a_o,
   output dsp_router_pkg::sample_t  dat_b_o,
   output logic                     sat_a_o,
   output logic                     sat_b_o
);
   import dsp_router_pkg::*;

   localparam int   N_DAC   = 2;
   localparam sum_t SUM_MAX = sum_t'(2**(`SAMPLE_W-1) - 1);   // +8191
   localparam sum_t SUM_MIN = sum_t'(-(2**(`SAMPLE_W-1)));    // -8192

   sum_t    mix_d   [N_DAC];
   sum_t    mix_q   [N_DAC];   // masked pair stage
   sum_t    sum_q   [N_DAC];   // sum stage
   sample_t dat_sat [N_DAC];
   logic    ovf     [N_DAC];

   // add each direct input whose mask bit picks this dac
   always_comb begin
      for (int d = 0; d < N_DAC; d++) begin
         mix_d[d] = '0;
         for (int k = 0; k < `N_DIRECT; k++) begin
            if (out_sel_i[k][d])
               mix_d[d] = mix_d[d] + sum_t'(direct_i[k]);   // sign extended
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int d = 0; d < N_DAC; d++) begin
            mix_q[d] <= '0;
            sum_q[d] <= '0;
         end
      end else begin
         mix_q <= mix_d;
         sum_q <= mix_q;
      end
   end

   // clamp to 14 bits, flag follows the registered sum
   always_comb begin
      for (int d = 0; d < N_DAC; d++) begin
         if (sum_q[d] > SUM_MAX) begin
            dat_sat[d] = sample_t'(SUM_MAX);
            ovf[d]     = 1'b1;
         end else if (sum_q[d] < SUM_MIN) begin
            dat_sat[d] = sample_t'(SUM_MIN);
            ovf[d]     = 1'b1;
         end else begin
            dat_sat[d] = sample_t'(sum_q[d]);
            ovf[d]     = 1'b0;
         end
      end
   end

   assign dat_a_o = dat_sat[0];   // mask bit 0
   assign dat_b_o = dat_sat[1];
   assign sat_a_o = ovf[0];
   assign sat_b_o = ovf[1];

endmodule

`default_nettype wire

// ==== source/dsp_router.sv ====
// router top level joining register file, source crossbar and dac mixer
`timescale 1ns/1ps
`default_nettype none

`include "dsp_router_defs.svh"

module dsp_router (
   input  logic                    clk_i,
   input  logic                    rstn_i,
   input  dsp_router_pkg::sample_t dat_a_i,     // adc ch a
   input  dsp_router_pkg::sample_t dat_b_i,     // adc ch b
   input  dsp_router_pkg::sample_t asg1_i,
   input  dsp_router_pkg::sample_t asg2_i,
   input  logic [31:0]             sys_addr_i,
   input  logic [31:0]             sys_wdata_i,
   input  logic                    sys_wen_i,
   input  logic                    sys_ren_i,
   output dsp_router_pkg::sample_t dat_a_o,     // dac ch a
   output dsp_router_pkg::sample_t dat_b_o,     // dac ch b
   output dsp_router_pkg::sample_t scope1_o,
   output dsp_router_pkg::sample_t scope2_o,
   output dsp_router_pkg::sample_t pwm0_o,
   output dsp_router_pkg::sample_t pwm1_o,
   output logic [31:0]             sys_rdata_o,
   output logic                    sys_ack_o,
   output logic                    sys_err_o
);
   import dsp_router_pkg::*;

   sample_t  sources [`N_SOURCES];
   sample_t  sinks   [`N_SINKS];
   sample_t  direct  [`N_DIRECT];   // asg direct paths
   src_sel_t in_sel  [`N_SINKS];
   out_sel_t out_sel [`N_DIRECT];
   logic     sat_a;
   logic     sat_b;

   // routable sources, dac outputs looped back
   assign sources[SRC_ASG1] = asg1_i;
   assign sources[SRC_ASG2] = asg2_i;
   assign sources[SRC_ADC1] = dat_a_i;
   assign sources[SRC_ADC2] = dat_b_i;
   assign sources[SRC_DAC1] = dat_a_o;
   assign sources[SRC_DAC2] = dat_b_o;

   assign direct[0] = asg1_i;
   assign direct[1] = asg2_i;

   assign scope1_o = sinks[SINK_SCOPE1];
   assign scope2_o = sinks[SINK_SCOPE2];
   assign pwm0_o   = sinks[SINK_PWM0];
   assign pwm1_o   = sinks[SINK_PWM1];

   dsp_router_regs dsp_router_regs_i (
      .clk_i       (clk_i),
      .rstn_i      (rstn_i),
      .sys_addr_i  (sys_addr_i),
      .sys_wdata_i (sys_wdata_i),
      .sys_wen_i   (sys_wen_i),
      .sys_ren_i   (sys_ren_i),
      .sources_i   (sources),
      .sat_a_i     (sat_a),
      .sat_b_i     (sat_b),
      .in_sel_o    (in_sel),
      .out_sel_o   (out_sel),
      .sys_rdata_o (sys_rdata_o),
      .sys_ack_o   (sys_ack_o),
      .sys_err_o   (sys_err_o)
   );

   signal_crossbar signal_crossbar_i (
      .sources_i (sources),
      .in_sel_i  (in_sel),
      .sinks_o   (sinks)
   );

   dac_mixer dac_mixer_i (
      .clk_i     (clk_i),
      .rstn_i    (rstn_i),
      .direct_i  (direct),
      .out_sel_i (out_sel),
      .dat_a_o   (dat_a_o),
      .dat_b_o   (dat_b_o),
      .sat_a_o   (sat_a),
      .sat_b_o   (sat_b)
   );

endmodule

`default_nettype wire

// ==== test/dsp_router_chk.sv ====
// bound concurrent assertions on the strobe bus ack and err outputs
`timescale 1ns/1ps
`default_nettype none

module dsp_router_chk (
   input logic clk_i,
   input logic rstn_i,
   input logic sys_wen_i,
   input logic sys_ren_i,
   input logic sys_ack_o,
   input logic sys_err_o
);

   // each strobe gets its ack on the next cycle
   ack_after_strobe: assert property (@(posedge clk_i) disable iff (!rstn_i)
      (sys_wen_i || sys_ren_i) |=> sys_ack_o)
      else $error("ack missing one cycle after a strobe");

   // no spurious ack
   ack_needs_strobe: assert property (@(posedge clk_i) disable iff (!rstn_i)
      sys_ack_o |-> $past(sys_wen_i || sys_ren_i))
      else $error("ack without a strobe in the previous cycle");

   no_bus_error: assert property (@(posedge clk_i) disable iff (!rstn_i)
      !sys_err_o)
      else $error("bus error output went high");   // err tied low

endmodule

bind dsp_router_regs dsp_router_chk dsp_router_chk_i (.*);

`default_nettype wire

// ==== test/dsp_router_tb.sv ====
// clock, reset, trace driven bus and sample stimulus with output checks
`timescale 1ns/1ps
`default_nettype none

`include "dsp_router_defs.svh"

module dsp_router_tb;
   import dsp_router_pkg::*;

   localparam int ACK_TIMEOUT = 16;   // cycles from strobe
   localparam int MAX_WAIT    = 64;

   logic             clk_i;
   logic             rstn_i;
   sample_t          dat_a_i;
   sample_t          dat_b_i;
   sample_t          asg1_i;
   sample_t          asg2_i;
   logic [31:0]      sys_addr_i;
   logic [31:0]      sys_wdata_i;
   logic             sys_wen_i;
   logic             sys_ren_i;
   sample_t          dat_a_o;
   sample_t          dat_b_o;
   sample_t          scope1_o;
   sample_t          scope2_o;
   sample_t          pwm0_o;
   sample_t          pwm1_o;
   logic [31:0]      sys_rdata_o;
   logic             sys_ack_o;
   logic             sys_err_o;

   int               fd;
   int               n;
   int               steps;      // executed trace lines
   logic [8*8-1:0]   op;         // opcode token
   logic [8*160-1:0] line;
   logic [31:0]      fa;         // address, index or count
   logic [31:0]      fb;         // data or expected value

   dsp_router dsp_router_i (.*);

   always #4 clk_i = ~clk_i;   // 8 ns period

   task automatic abort_run(input string why);
      $display("Error at %0t ns: %s", $time, why);
      $display("Simulation FAILED");
      $fatal(1, "run aborted");
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      if (act !== exp) begin
         $display("Mismatch at %0t ns: %s expected %h got %h", $time, name, exp, act);
         $display("Simulation FAILED");
         $fatal(1, "value check failed");
      end
   endtask

   // trace holds raw 14 bit patterns
   function automatic logic [31:0] zext(input sample_t s);
      return {{(32-`SAMPLE_W){1'b0}}, s};
   endfunction

   // single strobe cycle, then ack wait, read data checked on ack
   task automatic bus_access(input logic wr, input logic [31:0] addr,
                             input logic [31:0] data);
      int cycles;
      sys_addr_i  = addr;
      sys_wdata_i = wr ? data : 32'd0;
      sys_wen_i   = wr;
      sys_ren_i   = !wr;
      @(posedge clk_i);
      #1;
      sys_wen_i = 1'b0;
      sys_ren_i = 1'b0;
      cycles    = 1;
      while (!sys_ack_o) begin
         if (cycles >= ACK_TIMEOUT)
            abort_run("bus ack never came after the strobe");
         @(posedge clk_i);
         #1;
         cycles++;
      end
      check_value("sys_err_o", 32'd0, {31'd0, sys_err_o});   // bus has no error response
      if (!wr)
         check_value("sys_rdata_o", data, sys_rdata_o);
   endtask

   task automatic set_sample(input logic [31:0] idx, input logic [31:0] val);
      case (idx)
         0: asg1_i  = val[`SAMPLE_W-1:0];
         1: asg2_i  = val[`SAMPLE_W-1:0];
         2: dat_a_i = val[`SAMPLE_W-1:0];   // adc a
         3: dat_b_i = val[`SAMPLE_W-1:0];
         default: abort_run("trace names an unknown sample input");
      endcase
   endtask

   task automatic check_output(input logic [31:0] idx, input logic [31:0] val);
      logic [31:0] exp;
      exp = zext(val[`SAMPLE_W-1:0]);
      case (idx)
         0: check_value("dat_a_o", exp, zext(dat_a_o));
         1: check_value("dat_b_o", exp, zext(dat_b_o));
         2: check_value("scope1_o", exp, zext(scope1_o));
         3: check_value("scope2_o", exp, zext(scope2_o));
         4: check_value("pwm0_o", exp, zext(pwm0_o));
         5: check_value("pwm1_o", exp, zext(pwm1_o));
         default: abort_run("trace names an unknown output");
      endcase
   endtask

   task automatic wait_cycles(input logic [31:0] count);
      if (count > MAX_WAIT)
         abort_run("wait count in trace is too large");
      for (int i = 0; i < count; i++) begin
         @(posedge clk_i);
         #1;
      end
   endtask

   initial begin
      clk_i       = 1'b0;
      rstn_i      = 1'b0;
      dat_a_i     = '0;
      dat_b_i     = '0;
      asg1_i      = '0;
      asg2_i      = '0;
      sys_addr_i  = '0;
      sys_wdata_i = '0;
      sys_wen_i   = 1'b0;
      sys_ren_i   = 1'b0;
      steps       = 0;
      fd = $fopen("test/dsp_router_trace.txt", "r");
      if (fd == 0)
         abort_run("cannot open test/dsp_router_trace.txt");
      repeat (4) @(posedge clk_i);   // reset held 4 cycles
      #1;
      rstn_i = 1'b1;
      while (!$feof(fd)) begin
         line = '0;
         if ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s %h %h", op, fa, fb);
            if (n == 3 && op != "#") begin
               case (op)
                  "S": set_sample(fa, fb);
                  "W": bus_access(1'b1, fa, fb);
                  "R": bus_access(1'b0, fa, fb);
                  "N": wait_cycles(fa);
                  "C": check_output(fa, fb);
                  default: abort_run("trace holds an unknown opcode");
               endcase
               steps++;
            end else if (n > 0 && op != "#") begin
               abort_run("malformed trace line");
            end
         end
      end
      $fclose(fd);
      if (steps == 0) begin
         abort_run("trace file held no steps");
      end else begin
         $display("Simulation PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== test/dsp_router_trace.txt ====
# columns: op field value, all hex; S idx sample, W addr data, R addr expected
# N cycles 0, C out expected; out 0 dac a 1 dac b 2 scope1 3 scope2 4 pwm0 5 pwm1
S 2 0123              adc a
S 3 3f00              adc b -256
S 0 0064              asg1 100
S 1 3fce              asg2 -50
R 00000000 00000002   scope1 sel adc1
R 00010000 00000003
R 00020000 00000007
R 00030000 00000007
R 00000004 00000000
R 00010004 00000000
C 2 0123
C 3 3f00
C 4 0000
C 5 0000
C 0 0000
C 1 0000
W 00020000 00000001   pwm0 from asg2
W 00000000 00000007   scope1 silent
W 00050000 00000001   bad slot ignored
W 00000040 00000001   bad offset ignored
C 4 3fce
C 2 0000
R 00000000 00000007
R 00010000 00000003
R 00050000 00000000
W 00000004 00000001   asg1 to dac a
W 00010004 00000003   asg2 to both
N 2 0
C 0 0032              100 - 50
C 1 3fce
W 00030000 00000004   pwm1 from dac a
C 5 0032
S 0 1f40              8000
S 1 1f40
N 2 0
C 0 1fff              clamped
C 1 1f40
R 00000008 00000001
W 00000004 00000000
W 00010004 00000000
N 2 0
C 0 0000
R 00000008 00000000
R 00000010 00001f40   asg1
R 00010010 00001f40
R 00020010 00000123
R 00030010 00003f00
R 00040010 00000000   dac a
R 00060010 00000000
R 00000020 00000000   unknown offset

// ==== build.f ====
+incdir+common
common/dsp_router_pkg.sv
source/signal_crossbar.sv
source/dsp_router_regs.sv
dac_mixer/dac_mixer.sv
source/dsp_router.sv
test/dsp_router_chk.sv
test/dsp_router_tb.sv

// ==== Makefile ====
# verilator lint, simulation and cleanup for the signal router
VERILATOR  := verilator
TB_TOP     := dsp_router_tb
RTL_TOP    := dsp_router
FILELIST   := build.f
COMMON     := --timing --assert --timescale 1ns/1ps
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary $(COMMON) -j 0
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP)
	./obj_dir/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation PASSED" $(LOG) || { echo "run ended early, see $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
